//--- hw/sound_pkg.sv
// sound block shared definitions
// sample, register and period types, FM map constants and the saturating add
package sound_pkg;

    typedef logic [15:0] sample_t;    // signed meaning
    typedef logic [7:0]  io_byte_t;
    typedef logic [15:0] phase_t;     // accumulator and increment
    typedef logic [15:0] period_t;    // cycles per sample or per dma byte
    typedef logic [2:0]  atten_t;     // right shift of the amplitude
    typedef logic [1:0]  chan_idx_t;

    typedef enum logic [1:0] {
        FM_FREQ_LO = 2'd0,
        FM_FREQ_HI = 2'd1,
        FM_LEVEL   = 2'd2
    } fm_reg_t;                       // 2'd3 never leaves the decoder on a write

    typedef enum logic [2:0] {
        DSP_IDLE, DSP_WAIT_DAC, DSP_WAIT_LEN_LO, DSP_WAIT_LEN_HI, DSP_DMA_RUN
    } dsp_state_t;

    typedef enum logic [1:0] {
        MIX_IDLE, MIX_LOAD_1, MIX_LOAD_2, MIX_WRITE
    } mix_state_t;

    localparam int         FM_CHANNELS             = 4;
    localparam sample_t    FM_AMPLITUDE            = 16'd8192;
    localparam sample_t    SAMPLE_MAX              = 16'h7fff;
    localparam sample_t    SAMPLE_MIN              = 16'h8000;
    localparam sample_t    SPEAKER_LOW             = 16'd16384;
    localparam sample_t    SPEAKER_HIGH            = 16'd49152;
    localparam io_byte_t   DSP_READY_BYTE          = 8'hAA;
    localparam logic [8:0] MGMT_DMA_PERIOD_ADDR    = 9'd0;
    localparam logic [8:0] MGMT_SAMPLE_PERIOD_ADDR = 9'd257;
    localparam period_t    DEFAULT_SAMPLE_PERIOD   = 16'd64;
    localparam period_t    DEFAULT_DMA_PERIOD      = 16'd200;

    // two's complement add, clamped on overflow
    function automatic sample_t sat_add(sample_t a, sample_t b);
        sample_t s;
        s = a + b;
        if (!a[15] && !b[15] && s[15])
            return SAMPLE_MAX;        // positive overflow
        if (a[15] && b[15] && !s[15])
            return SAMPLE_MIN;        // negative overflow
        return s;
    endfunction

endpackage

//--- hw/sound_fm_bus_if.sv
// FM register bus
// decoded channel register writes and the sample tick, decoder to tone channels
`timescale 1ns/10ps

interface sound_fm_bus_if;
    import sound_pkg::*;

    logic      wr;          // one-cycle write strobe
    chan_idx_t chan_sel;    // target channel
    fm_reg_t   kind;        // register inside the channel
    io_byte_t  data;        // write data
    logic      tick;        // sample tick pulse

    // decoder side
    modport ctrl (
        output wr, chan_sel, kind, data, tick
    );

    // tone channel side
    modport chan (
        input wr, chan_sel, kind, data, tick
    );

endinterface

//--- hw/sound_fm_regs.sv
// FM register decoder
// index latch, channel register decode, key status and the sample tick counter
`timescale 1ns/10ps

module sound_fm_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fm_address,
    input  logic                fm_write,
    input  sound_pkg::io_byte_t fm_writedata,
    input  logic [3:0]          io_address,
    input  logic                io_write,
    input  sound_pkg::io_byte_t io_writedata,
    output sound_pkg::io_byte_t status,
    input  logic [8:0]          mgmt_address,
    input  logic                mgmt_write,
    input  logic [31:0]         mgmt_writedata,
    sound_fm_bus_if.ctrl        bus
);
    import sound_pkg::*;

    io_byte_t               index;          // latched register index
    io_byte_t               wdata;
    logic                   addr_wr;
    logic                   data_wr;
    logic                   mapped;
    fm_reg_t                kind_dec;
    logic [FM_CHANNELS-1:0] key_bits;       // own copy of the key-on bits
    period_t                sample_period;
    period_t                tick_cnt;

    // 388h/389h win over the 228h/229h alias
    always_comb begin
        addr_wr = fm_write && !fm_address;
        data_wr = fm_write && fm_address;
        wdata   = fm_writedata;
        if (!fm_write && io_write) begin
            addr_wr = io_address == 4'h8;
            data_wr = io_address == 4'h9;
            wdata   = io_writedata;
        end
    end

    // index 0xh freq lo, 1xh freq hi, 2xh level; x below 4
    always_comb begin
        kind_dec = fm_reg_t'(2'd3);
        if (index[3:2] == 2'b00 && index[7:4] <= 4'h2)
            kind_dec = fm_reg_t'(index[5:4]);
        mapped = kind_dec inside {FM_FREQ_LO, FM_FREQ_HI, FM_LEVEL};
    end

    assign status = {7'd0, |key_bits};      // bit 0 any channel keyed

    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index        <= '0;
            key_bits     <= '0;
            bus.wr       <= 1'b0;
            bus.chan_sel <= '0;
            bus.kind     <= FM_FREQ_LO;
            bus.data     <= '0;
        end else begin
            if (addr_wr)
                index <= wdata;
            bus.wr       <= data_wr && mapped;  // unmapped index dropped
            bus.chan_sel <= index[1:0];
            bus.kind     <= kind_dec;
            bus.data     <= wdata;
            if (bus.wr && bus.kind == FM_LEVEL)
                key_bits[bus.chan_sel] <= bus.data[7];
        end
    end

    // sample tick, every sample_period cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_period <= DEFAULT_SAMPLE_PERIOD;
            tick_cnt      <= '0;
            bus.tick      <= 1'b0;
        end else begin
            if (mgmt_write && mgmt_address == MGMT_SAMPLE_PERIOD_ADDR)
                sample_period <= mgmt_writedata[15:0];
            bus.tick <= 1'b0;
            if (tick_cnt + 16'd1 >= sample_period) begin
                tick_cnt <= '0;
                bus.tick <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 16'd1;
            end
        end
    end

    a_wr_mapped: assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr |-> bus.kind inside {FM_FREQ_LO, FM_FREQ_HI, FM_LEVEL});

endmodule

//--- hw/sound_fm_channel.sv
// FM tone channel
// square wave from a phase accumulator, level set by key-on and attenuation
`timescale 1ns/10ps

module sound_fm_channel #(
    parameter int CHAN_INDEX = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    sound_fm_bus_if.chan       bus,
    output sound_pkg::sample_t level
);
    import sound_pkg::*;

    phase_t  incr;          // phase step per tick
    logic    key_on;
    atten_t  atten;
    phase_t  phase;
    phase_t  phase_next;
    sample_t amp;           // A for this attenuation
    logic    hit;

    if (CHAN_INDEX >= FM_CHANNELS) begin : g_bad_index
        $error("sound_fm_channel: CHAN_INDEX out of range");
    end

    assign hit        = bus.wr && bus.chan_sel == chan_idx_t'(CHAN_INDEX);
    assign phase_next = phase + incr;
    assign amp        = FM_AMPLITUDE >> atten;

    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            incr   <= '0;
            key_on <= 1'b0;
            atten  <= '0;
        end else if (hit) begin
            case (bus.kind)
                FM_FREQ_LO: incr[7:0]  <= bus.data;
                FM_FREQ_HI: incr[15:8] <= bus.data;
                FM_LEVEL: begin
                    key_on <= bus.data[7];      // key-on bit
                    atten  <= bus.data[2:0];
                end
                default: ;
            endcase
        end
    end

    // phase and square output, registered on the tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
            level <= '0;
        end else if (!key_on) begin
            phase <= '0;                        // keyed off, silent
            level <= '0;
        end else if (bus.tick) begin
            phase <= phase_next;
            level <= phase_next[15] ? -amp : amp;   // msb picks the half wave
        end
    end

endmodule

//--- hw/sound_fm_summer.sv
// FM channel summer
// saturating sum of all tone channels, registered and strobed per sample tick
`timescale 1ns/10ps

module sound_fm_summer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  sound_pkg::sample_t levels [sound_pkg::FM_CHANNELS],
    output logic               fm_sample_strobe,
    output sound_pkg::sample_t fm_sample
);
    import sound_pkg::*;

    logic    tick_d;        // channel outputs settle here
    sample_t sum;

    // clamp at every step
    always_comb begin
        sum = '0;
        for (int i = 0; i < FM_CHANNELS; i++)
            sum = sat_add(sum, levels[i]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_d           <= 1'b0;
            fm_sample_strobe <= 1'b0;
        end else begin
            tick_d           <= tick;
            fm_sample_strobe <= tick_d;     // two cycles after the tick
        end
    end

    always_ff @(posedge clk) begin
        if (tick_d)
            fm_sample <= sum;
    end

    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        fm_sample_strobe |=> !fm_sample_strobe);

endmodule

//--- hw/sound_dsp.sv
// Sound Blaster style DSP
// reset/ready handshake, direct and DMA 8-bit playback, irq on DMA end
`timescale 1ns/10ps

module sound_dsp (
    input  logic                clk,
    input  logic                rst_n,
    output logic                irq,
    input  logic [3:0]          io_address,
    input  logic                io_read,
    input  logic                io_write,
    input  sound_pkg::io_byte_t io_writedata,
    output sound_pkg::io_byte_t dsp_readdata,
    output logic                dma_soundblaster_req,
    input  logic                dma_soundblaster_ack,
    input  logic                dma_soundblaster_terminal,
    input  sound_pkg::io_byte_t dma_soundblaster_readdata,
    output logic                dsp_disabled,
    output logic                dsp_sample_strobe,
    output sound_pkg::io_byte_t dsp_sample,
    input  logic [8:0]          mgmt_address,
    input  logic                mgmt_write,
    input  logic [31:0]         mgmt_writedata
);
    import sound_pkg::*;

    dsp_state_t  state;
    logic        reset_bit;     // last bit written to port 6
    logic        data_avail;
    io_byte_t    out_byte;      // queued read byte
    logic [15:0] dma_len;       // length minus 1
    logic [15:0] dma_count;     // bytes taken
    period_t     dma_period;
    period_t     dma_cnt;       // byte pacing

    wire wr_cmd    = io_write && io_address == 4'hC;
    wire rd_data   = io_read && io_address == 4'hA;
    wire rd_status = io_read && io_address == 4'hE;
    wire dsp_reset = io_write && io_address == 4'h6 && reset_bit && !io_writedata[0];
    wire dma_take  = state == DSP_DMA_RUN && dma_soundblaster_ack && !dsp_reset;
    wire dma_last  = dma_count == dma_len || dma_soundblaster_terminal;

    always_comb begin
        case (io_address)
            4'hA:    dsp_readdata = out_byte;
            4'hC:    dsp_readdata = 8'h00;                  // always ready for a write
            4'hE:    dsp_readdata = {data_avail, 7'd0};
            default: dsp_readdata = 8'hFF;
        endcase
    end

    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_bit  <= 1'b0;
            dma_period <= DEFAULT_DMA_PERIOD;
            data_avail <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (io_write && io_address == 4'h6)
                reset_bit <= io_writedata[0];
            if (mgmt_write && mgmt_address == MGMT_DMA_PERIOD_ADDR)
                dma_period <= mgmt_writedata[15:0];
            if (dsp_reset)
                data_avail <= 1'b1;                         // ready byte queued
            else if (rd_data)
                data_avail <= 1'b0;
            if (dma_take && dma_last)
                irq <= 1'b1;
            else if (rd_status)
                irq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dsp_reset)
            out_byte <= DSP_READY_BYTE;
        if (state == DSP_WAIT_DAC && wr_cmd && !dsp_reset)
            dsp_sample <= io_writedata;
        else if (dma_take)
            dsp_sample <= dma_soundblaster_readdata;
    end

    // command FSM and dma pacing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                <= DSP_IDLE;
            dsp_disabled         <= 1'b1;
            dsp_sample_strobe    <= 1'b0;
            dma_soundblaster_req <= 1'b0;
            dma_len              <= '0;
            dma_count            <= '0;
            dma_cnt              <= '0;
        end else begin
            dsp_sample_strobe <= 1'b0;
            if (dsp_reset) begin
                state                <= DSP_IDLE;       // abort playback
                dma_soundblaster_req <= 1'b0;
            end else begin
                case (state)
                    DSP_IDLE: if (wr_cmd) begin
                        case (io_writedata)
                            8'h10:   state <= DSP_WAIT_DAC;
                            8'h14:   state <= DSP_WAIT_LEN_LO;
                            8'hD1:   dsp_disabled <= 1'b0;  // speaker on
                            8'hD3:   dsp_disabled <= 1'b1;  // speaker off
                            default: ;
                        endcase
                    end
                    DSP_WAIT_DAC: if (wr_cmd) begin
                        dsp_sample_strobe <= 1'b1;
                        state             <= DSP_IDLE;
                    end
                    DSP_WAIT_LEN_LO: if (wr_cmd) begin
                        dma_len[7:0] <= io_writedata;
                        state        <= DSP_WAIT_LEN_HI;
                    end
                    DSP_WAIT_LEN_HI: if (wr_cmd) begin
                        dma_len[15:8] <= io_writedata;
                        dma_count     <= '0;
                        dma_cnt       <= '0;
                        state         <= DSP_DMA_RUN;
                    end
                    DSP_DMA_RUN: begin
                        if (dma_soundblaster_ack) begin
                            dma_soundblaster_req <= 1'b0;   // quiet for one period
                            dma_cnt              <= '0;
                            dma_count            <= dma_count + 16'd1;
                            dsp_sample_strobe    <= 1'b1;
                            if (dma_last)
                                state <= DSP_IDLE;
                        end else if (!dma_soundblaster_req) begin
                            if (dma_cnt + 16'd1 >= dma_period)
                                dma_soundblaster_req <= 1'b1;
                            else
                                dma_cnt <= dma_cnt + 16'd1;
                        end
                    end
                    default: state <= DSP_IDLE;
                endcase
            end
        end
    end

    a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        dma_soundblaster_ack |-> dma_soundblaster_req);

endmodule

//--- hw/sound.sv
// Sound block top level
// DSP, FM tones and PC speaker mixed with saturation into one audio master stream
`timescale 1ns/10ps

module sound (
    input  logic        clk,
    input  logic        rst_n,
    output logic        irq,
    input  logic        speaker_enable,
    input  logic        speaker_out,
    input  logic [3:0]  io_address,             // 220h-22Fh
    input  logic        io_read,
    input  logic        io_write,
    input  logic [7:0]  io_writedata,
    output logic [7:0]  io_readdata,
    input  logic        fm_address,             // 388h-389h
    input  logic        fm_read,
    input  logic        fm_write,
    input  logic [7:0]  fm_writedata,
    output logic [7:0]  fm_readdata,
    output logic        dma_soundblaster_req,
    input  logic        dma_soundblaster_ack,
    input  logic        dma_soundblaster_terminal,
    input  logic [7:0]  dma_soundblaster_readdata,
    output logic [2:0]  avm_address,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest,
    input  logic [8:0]  mgmt_address,
    input  logic        mgmt_write,
    input  logic [31:0] mgmt_writedata
);
    import sound_pkg::*;

    io_byte_t   dsp_readdata;
    io_byte_t   fm_status;
    logic       dsp_disabled;
    logic       dsp_sample_strobe;
    io_byte_t   dsp_sample;
    sample_t    fm_levels [FM_CHANNELS];
    logic       fm_sample_strobe;
    sample_t    fm_sample;
    sample_t    dsp_level;          // dsp byte as signed sample
    sample_t    speaker_level;
    sample_t    sum_1;              // dsp + fm
    sample_t    sum_2;              // + speaker
    mix_state_t mix_state;

    sound_fm_bus_if fm_bus ();

    sound_dsp u_dsp (.*);

    sound_fm_regs u_fm_regs (
        .clk, .rst_n, .fm_address, .fm_write, .fm_writedata,
        .io_address, .io_write, .io_writedata, .status(fm_status),
        .mgmt_address, .mgmt_write, .mgmt_writedata, .bus(fm_bus.ctrl)
    );

    for (genvar i = 0; i < FM_CHANNELS; i++) begin : g_chan
        sound_fm_channel #(.CHAN_INDEX(i)) u_chan (
            .clk, .rst_n, .bus(fm_bus.chan), .level(fm_levels[i])
        );
    end

    sound_fm_summer u_fm_summer (
        .clk, .rst_n, .tick(fm_bus.tick), .levels(fm_levels), .fm_sample_strobe, .fm_sample
    );

    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_readdata   <= '0;
            fm_readdata   <= '0;
            speaker_level <= '0;
            dsp_level     <= '0;
        end else begin
            io_readdata <= (io_address == 4'h8 || io_address == 4'h9) ? fm_status : dsp_readdata;
            if (fm_read)
                fm_readdata <= fm_status;       // both fm ports read status
            speaker_level <= !speaker_enable ? '0 : speaker_out ? SPEAKER_HIGH : SPEAKER_LOW;
            if (dsp_disabled)
                dsp_level <= '0;
            else if (dsp_sample_strobe)
                dsp_level <= {dsp_sample, 8'd0} - 16'h8000;     // unsigned to signed
        end
    end

    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mix_state <= MIX_IDLE;
        else begin
            case (mix_state)
                MIX_IDLE:   if (fm_sample_strobe) mix_state <= MIX_LOAD_1;
                MIX_LOAD_1: mix_state <= MIX_LOAD_2;
                MIX_LOAD_2: mix_state <= MIX_WRITE;
                MIX_WRITE:  if (!avm_waitrequest) mix_state <= MIX_IDLE;
                default:    mix_state <= MIX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mix_state == MIX_LOAD_1)
            sum_1 <= sat_add(dsp_level, fm_sample);
        if (mix_state == MIX_LOAD_2)
            sum_2 <= sat_add(sum_1, speaker_level);
    end

    assign avm_address   = 3'd0;
    assign avm_write     = mix_state == MIX_WRITE;
    assign avm_writedata = {16'd0, sum_2};

    a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
        avm_write && avm_waitrequest |=> avm_write);

endmodule

//--- dv/sound_model.svh
// Sound block reference model
// saturating add, DSP byte to sample, FM square wave, speaker level and mixer output
`ifndef SOUND_MODEL_SVH
`define SOUND_MODEL_SVH

// clamp the true sum of two 16-bit samples to the 16-bit range
function automatic logic [15:0] model_sat_add(input logic [15:0] a, input logic [15:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > 32767)
        s = 32767;
    else if (s < -32768)
        s = -32768;
    return s[15:0];
endfunction

// unsigned 8-bit sample centered on zero
function automatic logic [15:0] dsp_sample_level(input logic [7:0] v);
    int s;
    s = int'(v) * 256 - 32768;
    return s[15:0];
endfunction

function automatic logic [15:0] fm_amplitude(input logic [2:0] atten);
    return 16'd8192 >> atten;           // full tone 8192
endfunction

// msb of the phase picks the negative half
function automatic logic [15:0] fm_square(input logic [15:0] phase, input logic [2:0] atten);
    if (phase[15])
        return 16'd0 - fm_amplitude(atten);
    return fm_amplitude(atten);
endfunction

function automatic logic [15:0] speaker_sample(input logic en, input logic out);
    if (!en)
        return 16'd0;
    return out ? 16'd49152 : 16'd16384;
endfunction

// four channels at one level, then dsp and speaker, clamped at every add
function automatic logic [15:0] mixer_out(input logic [15:0] dsp, input logic [15:0] chan,
                                          input logic [15:0] spk);
    logic [15:0] fm;
    fm = 16'd0;
    for (int i = 0; i < 4; i++)
        fm = model_sat_add(fm, chan);
    return model_sat_add(model_sat_add(dsp, fm), spk);
endfunction

`endif

//--- dv/sound_tb.sv
// Sound block testbench
// LFSR driven stimulus on the io, FM, DMA and audio ports, checked against the model
`timescale 1ns/10ps

module sound_tb;

    localparam int CYCLE_LIMIT = 40000;     // tests need about 5000 cycles

    logic        clk;
    logic        rst_n;
    logic        irq;
    logic        speaker_enable, speaker_out;
    logic [3:0]  io_address;
    logic        io_read, io_write;
    logic [7:0]  io_writedata, io_readdata;
    logic        fm_address, fm_read, fm_write;
    logic [7:0]  fm_writedata, fm_readdata;
    logic        dma_soundblaster_req, dma_soundblaster_ack, dma_soundblaster_terminal;
    logic [7:0]  dma_soundblaster_readdata;
    logic [2:0]  avm_address;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b1;    // high until the hold runs out
    logic [8:0]  mgmt_address;
    logic        mgmt_write;
    logic [31:0] mgmt_writedata;

    logic [31:0] lfsr      = 32'hc6c5bd2a;  // stimulus stream
    logic [31:0] wait_lfsr = 32'hc6c5bd2a;  // waitrequest stream
    logic [1:0]  hold_left = 2'd0;
    logic [1:0]  hold_new;
    int          wr_count  = 0;             // accepted avm writes
    logic [31:0] wr_data;
    logic [2:0]  wr_addr;
    int          cycles    = 0;
    int          checks    = 0;
    int          errors    = 0;
    int          tests     = 0;
    int          failed_tests = 0;

    `include "sound_model.svh"

    sound uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};      // one step per bit
            lfsr = galois_step(lfsr);
        end
        return r;
    endfunction

    //--------------------------------------------------
    // audio master slave side, random extra hold of 0-3 cycles
    always @(posedge clk) begin
        if (avm_write && !avm_waitrequest) begin
            wr_data         <= avm_writedata;
            wr_addr         <= avm_address;
            wr_count        <= wr_count + 1;
            hold_new[1]      = wait_lfsr[0];
            wait_lfsr        = galois_step(wait_lfsr);
            hold_new[0]      = wait_lfsr[0];
            wait_lfsr        = galois_step(wait_lfsr);
            avm_waitrequest <= hold_new != 2'd0;    // zero hold keeps it low
            hold_left       <= hold_new - 2'd1;
        end else if (avm_write) begin
            if (hold_left == 2'd0)
                avm_waitrequest <= 1'b0;
            else
                hold_left <= hold_left - 2'd1;
        end
    end

    task automatic write_io(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        io_address   <= addr;
        io_writedata <= data;
        io_write     <= 1'b1;
        @(posedge clk);
        io_write <= 1'b0;
    endtask

    task automatic read_io(input logic [3:0] addr, output logic [7:0] data);
        @(posedge clk);
        io_address <= addr;
        io_read    <= 1'b1;
        @(posedge clk);
        io_read <= 1'b0;
        @(posedge clk);
        data = io_readdata;                 // one cycle after the address
    endtask

    task automatic write_fm(input logic addr, input logic [7:0] data);
        @(posedge clk);
        fm_address   <= addr;
        fm_writedata <= data;
        fm_write     <= 1'b1;
        @(posedge clk);
        fm_write <= 1'b0;
    endtask

    task automatic read_fm(output logic [7:0] data);
        @(posedge clk);
        fm_address <= 1'b0;
        fm_read    <= 1'b1;
        @(posedge clk);
        fm_read <= 1'b0;
        @(posedge clk);
        data = fm_readdata;
    endtask

    task automatic set_fm_reg(input logic [7:0] index, input logic [7:0] data);
        write_fm(1'b0, index);
        write_fm(1'b1, data);
    endtask

    task automatic write_mgmt(input logic [8:0] addr, input logic [31:0] data);
        @(posedge clk);
        mgmt_address   <= addr;
        mgmt_writedata <= data;
        mgmt_write     <= 1'b1;
        @(posedge clk);
        mgmt_write <= 1'b0;
    endtask

    task automatic next_avm_write(output logic [31:0] data, output logic [2:0] addr);
        int start;
        start = wr_count;
        @(posedge clk);
        while (wr_count == start)
            @(posedge clk);
        data = wr_data;
        addr = wr_addr;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_either(input string name, input logic [15:0] got,
                                input logic [15:0] a, input logic [15:0] b);
        checks++;
        assert (got === a || got === b) else begin
            $display("error %s: got %h, expected %h or %h", name, got, a, b);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    //--------------------------------------------------
    initial begin
        logic [7:0]  v;
        logic [7:0]  rd;
        logic [31:0] data;
        logic [2:0]  addr;
        logic [1:0]  ch;
        logic [2:0]  atten;
        logic [15:0] amp;
        logic [15:0] phase;
        logic [15:0] pos_out;
        logic [15:0] neg_out;
        logic        spk;
        int          len;
        int          acks;
        int          quiet;
        int          clamps;
        int          err0;

        rst_n                     = 1'b0;
        speaker_enable            = 1'b0;
        speaker_out               = 1'b0;
        io_address                = 4'h0;
        io_read                   = 1'b0;
        io_write                  = 1'b0;
        io_writedata              = 8'h00;
        fm_address                = 1'b0;
        fm_read                   = 1'b0;
        fm_write                  = 1'b0;
        fm_writedata              = 8'h00;
        dma_soundblaster_ack      = 1'b0;
        dma_soundblaster_terminal = 1'b0;
        dma_soundblaster_readdata = 8'h00;
        mgmt_address              = 9'd0;
        mgmt_write                = 1'b0;
        mgmt_writedata            = 32'd0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        write_mgmt(9'd257, 32'd64);         // sample period

        // dsp reset and ready byte
        err0 = errors;
        write_io(4'h6, 8'h01);
        write_io(4'h6, 8'h00);
        read_io(4'hE, rd);
        check_value("io_readdata[7] port E", 32'(rd[7]), 32'h1);
        read_io(4'hA, rd);
        check_value("io_readdata port A", 32'(rd), 32'hAA);
        read_io(4'hE, rd);
        check_value("io_readdata[7] port E", 32'(rd[7]), 32'h0);
        report_test("dsp reset", err0);

        // direct sample, fm and speaker silent
        err0 = errors;
        write_io(4'hC, 8'hD1);
        v = 8'(rand_bits(8));
        write_io(4'hC, 8'h10);
        write_io(4'hC, v);
        next_avm_write(data, addr);         // may have mixed before the sample
        next_avm_write(data, addr);
        check_value("avm_writedata[15:0]", 32'(data[15:0]), 32'(dsp_sample_level(v)));
        check_value("avm_writedata[31:16]", 32'(data[31:16]), 32'h0);
        check_value("avm_address", 32'(addr), 32'h0);
        report_test("direct sample", err0);

        // one fm channel, half-period increment
        err0 = errors;
        write_io(4'hC, 8'hD3);
        ch    = 2'(rand_bits(2));
        atten = 3'(rand_bits(3));
        amp   = fm_amplitude(atten);
        set_fm_reg(8'h00 + 8'(ch), 8'h00);
        set_fm_reg(8'h10 + 8'(ch), 8'h80);
        set_fm_reg(8'h20 + 8'(ch), 8'h80 | 8'(atten));
        next_avm_write(data, addr);
        next_avm_write(data, addr);
        check_either("avm_writedata[15:0]", data[15:0], amp, 16'd0 - amp);
        phase = (data[15:0] == amp) ? 16'h0000 : 16'h8000;
        for (int i = 0; i < 8; i++) begin
            next_avm_write(data, addr);
            phase = phase + 16'h8000;
            check_value("avm_writedata[15:0]", 32'(data[15:0]), 32'(fm_square(phase, atten)));
        end
        read_fm(rd);
        check_value("fm_readdata[0]", 32'(rd[0]), 32'h1);
        set_fm_reg(8'h20 + 8'(ch), 8'h00);
        report_test("fm tone", err0);

        // four channels in phase plus speaker
        err0 = errors;
        spk = 1'(rand_bits(1));
        speaker_out    <= spk;
        speaker_enable <= 1'b1;
        for (int c = 0; c < 4; c++) begin
            set_fm_reg(8'h00 + 8'(c), 8'h00);
            set_fm_reg(8'h10 + 8'(c), 8'h80);
        end
        next_avm_write(data, addr);         // key-ons then fit between two ticks
        for (int c = 0; c < 4; c++)
            set_fm_reg(8'h20 + 8'(c), 8'h80);
        pos_out = mixer_out(16'd0, fm_square(16'h0000, 3'd0), speaker_sample(1'b1, spk));
        neg_out = mixer_out(16'd0, fm_square(16'h8000, 3'd0), speaker_sample(1'b1, spk));
        clamps  = 0;
        next_avm_write(data, addr);
        for (int i = 0; i < 8; i++) begin
            next_avm_write(data, addr);
            check_either("avm_writedata[15:0]", data[15:0], pos_out, neg_out);
            if (data[15:0] == 16'h7FFF || data[15:0] == 16'h8000)
                clamps++;
        end
        check_true(clamps > 0, "no clamped sample appeared in the saturation test");
        for (int c = 0; c < 4; c++)
            set_fm_reg(8'h20 + 8'(c), 8'h00);
        speaker_enable <= 1'b0;
        report_test("saturation", err0);

        // dma playback, one ack per request
        err0 = errors;
        len = 3 + int'(rand_bits(3));       // 3 to 10
        write_io(4'hC, 8'h14);
        write_io(4'hC, 8'(len));
        write_io(4'hC, 8'h00);
        acks  = 0;
        quiet = 0;
        while (quiet < 1000) begin          // five byte periods without a request
            @(posedge clk);
            if (dma_soundblaster_ack) begin
                dma_soundblaster_ack <= 1'b0;
            end else if (dma_soundblaster_req) begin
                dma_soundblaster_ack      <= 1'b1;
                dma_soundblaster_readdata <= 8'(rand_bits(8));
                acks++;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        check_value("dma_soundblaster_ack count", 32'(acks), 32'(len + 1));
        check_value("irq", 32'(irq), 32'h1);
        read_io(4'hE, rd);
        check_value("irq", 32'(irq), 32'h0);
        report_test("dma playback", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+dv
hw/sound_pkg.sv
hw/sound_fm_bus_if.sv
hw/sound_fm_regs.sv
hw/sound_fm_channel.sv
hw/sound_fm_summer.sv
hw/sound_dsp.sv
hw/sound.sv
dv/sound_tb.sv

//--- Makefile
# Verilator build and run of the sound block testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module sound_tb -f sources.f -Mdir obj_dir -o Vsound_tb

# the log decides pass or fail
run: compile
	-./obj_dir/Vsound_tb > run.log 2>&1
	cat run.log
	grep -q "Result: PASSED" run.log

clean:
	rm -rf obj_dir run.log
